//--- list.f
verilog/fpFormatPkg.sv
verilog/fpOpPkg.sv
verilog/fpbus.sv
verilog/OperandClassifier.sv
verilog/Alignment.sv
verilog/MantissaAdder.sv
verilog/Normalizer.sv
verilog/FpAddUnit.sv
tests/FpAddUnit_assert.sv
tests/FpAddUnitTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module FpAddUnitTb -f list.f -o simFpAdd

output=$(./obj_dir/simFpAdd 2>&1) || true
echo "$output"

if echo "$output" | grep -q "Verification passed"; then
    exit 0
fi
exit 1

//--- tests/FpAddUnitTb.sv
// Fixed cases are hand-worked IEEE-754 words; random cases are checked by rule, not by value.
`timescale 1ns/1ps

module FpAddUnitTb;

    localparam int clkPeriod    = 40;
    localparam int resetCycles  = 8;
    localparam int numFixed     = 12;
    localparam int numCancel    = 8;
    localparam int numSwapPairs = 8;
    localparam int numEntries   = numFixed + numCancel + 2 * numSwapPairs;
    localparam int ackEdges     = 2;                // Counting the edge that samples req.
    localparam int waitLimit    = 10;

    localparam logic [31:0] canonicalNaN = 32'h7FC0_0000;
    localparam logic [1:0]  modeExact    = 2'd0;
    localparam logic [1:0]  modeRecord   = 2'd1;    // First half of a swapped pair.
    localparam logic [1:0]  modeSwap     = 2'd2;

    logic        clk;
    logic        rstN;
    logic        req;
    logic        subtract;
    logic [31:0] opA;
    logic [31:0] opB;
    logic        ack;
    logic        invalid;
    logic        overflow;
    logic        inexact;
    logic [31:0] result;

    logic [31:0] tabA     [numEntries];
    logic [31:0] tabB     [numEntries];
    logic        tabSub   [numEntries];
    logic [31:0] tabRes   [numEntries];
    logic [2:0]  tabFlags [numEntries];             // Invalid, overflow, inexact.
    logic [1:0]  tabMode  [numEntries];

    logic [31:0] rngState;
    logic [31:0] prevResult;
    logic [2:0]  prevFlags;
    int          checks;
    int          valueErrors;
    int          timingErrors;

    FpAddUnit i_dut (
        .clk      (clk),
        .rstN     (rstN),
        .req      (req),
        .subtract (subtract),
        .opA      (opA),
        .opB      (opB),
        .ack      (ack),
        .invalid  (invalid),
        .overflow (overflow),
        .inexact  (inexact),
        .result   (result)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Pulls an all-ones exponent down so the word stays finite.
    function automatic logic [31:0] finiteWord(input logic [31:0] raw);
        logic [31:0] w;
        w = raw;
        if (raw[30:23] == 8'hFF)
            w[30] = 1'b0;
        return w;
    endfunction

    task automatic setEntry(input int idx, input logic [31:0] a, input logic [31:0] b,
                            input logic sub, input logic [31:0] res, input logic [2:0] flags,
                            input logic [1:0] mode);
        tabA[idx]     = a;
        tabB[idx]     = b;
        tabSub[idx]   = sub;
        tabRes[idx]   = res;
        tabFlags[idx] = flags;
        tabMode[idx]  = mode;
    endtask

    // --------------------------------------------------------------------------
    // Stimulus table
    // --------------------------------------------------------------------------
    task automatic fillTable();
        logic [31:0] x;
        logic [31:0] y;
        int          idx;
        setEntry(0, 32'h3F80_0000, 32'h3F80_0000, 1'b0, 32'h4000_0000, 3'b000, modeExact);
        setEntry(1, 32'h3FC0_0000, 32'h3E80_0000, 1'b1, 32'h3FA0_0000, 3'b000, modeExact);
        setEntry(2, 32'h4B80_0000, 32'h3F80_0000, 1'b0, 32'h4B80_0000, 3'b001, modeExact);
        setEntry(3, 32'h7F80_0001, 32'h3F80_0000, 1'b0, canonicalNaN, 3'b100, modeExact);
        setEntry(4, 32'h3F80_0000, 32'hFFC1_2345, 1'b1, canonicalNaN, 3'b100, modeExact);
        setEntry(5, 32'h7F80_0000, 32'h7F80_0000, 1'b1, canonicalNaN, 3'b100, modeExact);
        setEntry(6, 32'h7F80_0000, 32'h4000_0000, 1'b0, 32'h7F80_0000, 3'b000, modeExact);
        setEntry(7, 32'h3F80_0000, 32'hFF80_0000, 1'b0, 32'hFF80_0000, 3'b000, modeExact);
        setEntry(8, 32'h4049_0FDB, 32'h0000_0000, 1'b0, 32'h4049_0FDB, 3'b000, modeExact);
        setEntry(9, 32'h0000_0000, 32'h3F80_0000, 1'b1, 32'hBF80_0000, 3'b000, modeExact);
        setEntry(10, 32'h0000_0001, 32'h0000_0001, 1'b0, 32'h0000_0002, 3'b000, modeExact);
        setEntry(11, 32'h7F7F_FFFF, 32'h7F7F_FFFF, 1'b0, 32'h7F80_0000, 3'b011, modeExact);
        idx = numFixed;
        for (int i = 0; i < numCancel; i++)
        begin
            rngState = xorshift(rngState);
            x        = finiteWord(rngState);
            setEntry(idx, x, x, 1'b1, 32'h0000_0000, 3'b000, modeExact);    // Always +0.
            idx++;
        end
        for (int i = 0; i < numSwapPairs; i++)
        begin
            rngState = xorshift(rngState);
            x        = finiteWord(rngState);
            rngState = xorshift(rngState);
            y        = finiteWord({rngState[31], x[30:23] ^ {5'b0, rngState[25:23]},
                                   rngState[22:0]});                      // Nearby exponent.
            setEntry(idx, x, y, 1'b0, 32'h0, 3'b000, modeRecord);
            setEntry(idx + 1, y, x, 1'b0, 32'h0, 3'b000, modeSwap);
            idx = idx + 2;
        end
    endtask

    // --------------------------------------------------------------------------
    // One handshake
    // --------------------------------------------------------------------------
    task automatic applyEntry(input int idx);
        int edges;
        @(posedge clk);
        opA      <= tabA[idx];
        opB      <= tabB[idx];
        subtract <= tabSub[idx];
        req      <= 1'b1;
        edges = 0;
        do
        begin
            @(posedge clk);
            @(negedge clk);
            edges++;
        end
        while (!ack && edges < waitLimit);
        checks++;
        if (!ack)
        begin
            $display("Entry %0d: ack never rose after req was raised", idx);
            timingErrors++;
        end
        else if (edges != ackEdges)
        begin
            $display("FAIL %0t: entry %0d ack rose after %0d edges, expected %0d",
                     $time, idx, edges, ackEdges);
            timingErrors++;
        end
        checks++;
        if (tabMode[idx] == modeExact)
        begin
            if (result !== tabRes[idx] || {invalid, overflow, inexact} !== tabFlags[idx])
            begin
                $display("FAIL %0t: entry %0d %h %s %h gave %h flags %b, expected %h flags %b",
                         $time, idx, tabA[idx], tabSub[idx] ? "-" : "+", tabB[idx], result,
                         {invalid, overflow, inexact}, tabRes[idx], tabFlags[idx]);
                valueErrors++;
            end
        end
        else if (tabMode[idx] == modeSwap)
        begin
            if (result !== prevResult || {invalid, overflow, inexact} !== prevFlags)
            begin
                $display("FAIL %0t: entry %0d swapped sum %h flags %b, other order %h flags %b",
                         $time, idx, result, {invalid, overflow, inexact}, prevResult, prevFlags);
                valueErrors++;
            end
        end
        prevResult = result;
        prevFlags  = {invalid, overflow, inexact};
        @(posedge clk);
        req <= 1'b0;
        edges = 0;
        do
        begin
            @(posedge clk);
            @(negedge clk);
            edges++;
        end
        while (ack && edges < waitLimit);
        checks++;
        if (ack)
        begin
            $display("Entry %0d: ack stayed high after req was dropped", idx);
            timingErrors++;
        end
        else if (edges != 1)
        begin
            $display("FAIL %0t: entry %0d ack fell after %0d edges, expected 1", $time, idx, edges);
            timingErrors++;
        end
    endtask

    initial
    begin
        clk          = 1'b0;
        rstN         = 1'b0;
        req          = 1'b0;
        subtract     = 1'b0;
        opA          = '0;
        opB          = '0;
        rngState     = 32'd68434;
        prevResult   = '0;
        prevFlags    = '0;
        checks       = 0;
        valueErrors  = 0;
        timingErrors = 0;
        fillTable();
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checks++;
        if (ack !== 1'b0 || result !== 32'h0 || {invalid, overflow, inexact} !== 3'b000)
        begin
            $display("FAIL %0t: after reset ack %b result %h flags %b, expected all zero",
                     $time, ack, result, {invalid, overflow, inexact});
            valueErrors++;
        end
        for (int i = 0; i < numEntries; i++)
            applyEntry(i);
        $display("Checks run: %0d, value errors: %0d, timing errors: %0d",
                 checks, valueErrors, timingErrors);
        if (valueErrors + timingErrors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // Stops the run when a handshake hangs.
    initial
    begin
        #((numEntries * 10 + resetCycles) * clkPeriod);
        $display("Timeout: the handshakes did not finish in the allowed time");
        $display("Verification failed");
        $finish;
    end

endmodule

//--- tests/FpAddUnit_assert.sv
// Handshake checks on the top level only. They stay quiet while rstN is low.
`timescale 1ns/1ps

module FpAddUnitAssert (
    input logic        clk,
    input logic        rstN,
    input logic        req,
    input logic        ack,
    input logic [31:0] result
);

    // --------------------------------------------------------------------------
    // Four-phase ordering
    // --------------------------------------------------------------------------
    property ackRisesOnReq;
        @(posedge clk) disable iff (!rstN) $rose(ack) |-> $past(req);
    endproperty

    property ackFallsAfterReq;
        @(posedge clk) disable iff (!rstN) $fell(ack) |-> !$past(req);
    endproperty

    property resultHeldWithAck;
        @(posedge clk) disable iff (!rstN) (ack && $past(ack)) |-> $stable(result);
    endproperty

    ackRiseCheck:   assert property (ackRisesOnReq)     else $error("ack rose without req");
    ackFallCheck:   assert property (ackFallsAfterReq)  else $error("ack fell while req high");
    resultCheck:    assert property (resultHeldWithAck) else $error("result moved under ack");

endmodule

bind FpAddUnit FpAddUnitAssert i_assert (
    .clk    (clk),
    .rstN   (rstN),
    .req    (req),
    .ack    (ack),
    .result (result)
);

//--- verilog/FpAddUnit.sv
// Four-phase req/ack. Operands must stay stable while req is high and one operation runs at a time.
`timescale 1ns/1ps

module FpAddUnit (
    input  logic        clk,
    input  logic        rstN,
    input  logic        req,
    input  logic        subtract,
    input  logic [31:0] opA,
    input  logic [31:0] opB,
    output logic        ack,
    output logic        invalid,
    output logic        overflow,
    output logic        inexact,
    output logic [31:0] result
);
    import fpFormatPkg::*;
    import fpOpPkg::*;

    localparam int countWidth = $clog2(ackLatency + 1);

    logic                  busy;
    logic                  accept;
    logic [countWidth-1:0] waitCount;
    fpWord                 opAReg;
    fpWord                 opBReg;
    logic                  subtractReg;

    fpbus bus ();

    OperandClassifier i_classifier (
        .bus      (bus.classify),
        .opA      (opAReg),
        .opB      (opBReg),
        .subtract (subtractReg)
    );
    Alignment     i_alignment  (.bus(bus.align));
    MantissaAdder i_adder      (.bus(bus.adder));
    Normalizer    i_normalizer (.bus(bus.normalize));

    assign accept = req & ~busy & ~ack;

    // Operand capture.
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            opAReg.bits <= opA;
            opBReg.bits <= opB;
            subtractReg <= subtract;
        end
    end

    // --------------------------------------------------------------------------
    // Handshake and result registers
    // --------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            busy      <= 1'b0;
            ack       <= 1'b0;
            waitCount <= '0;
            result    <= '0;
            invalid   <= 1'b0;
            overflow  <= 1'b0;
            inexact   <= 1'b0;
        end
        else if (accept)
        begin
            busy      <= 1'b1;
            waitCount <= countWidth'(ackLatency - 1);
        end
        else if (busy)
        begin
            if (waitCount == countWidth'(1))
            begin
                busy     <= 1'b0;
                ack      <= 1'b1;
                result   <= bus.bypassALU ? bus.bypassResult : bus.normResult;
                invalid  <= bus.bypassALU & bus.bypassInvalid;
                overflow <= ~bus.bypassALU & bus.overflow;
                inexact  <= ~bus.bypassALU & bus.inexact;
            end
            else
                waitCount <= waitCount - 1'b1;
        end
        else if (ack && !req)
            ack <= 1'b0;                    // Requester let go.
    end

endmodule

//--- verilog/Normalizer.sv
// Round to nearest-even only. Subnormal results come out without an underflow flag.
`timescale 1ns/1ps

module Normalizer (fpbus.normalize bus);
    import fpFormatPkg::*;
    import fpOpPkg::*;

    localparam int lzWidth  = $clog2(alignWidth) + 1;
    localparam int extWidth = expWidth + 1;

    logic [lzWidth-1:0]    leadZeros;
    logic [extWidth-1:0]   shiftLimit;
    logic [extWidth-1:0]   expWork;
    logic [extWidth-1:0]   expFinal;
    logic [alignWidth-1:0] normMantissa;
    logic                  roundBit;
    logic                  stickyAll;
    logic                  roundUp;
    logic [fracWidth+1:0]  rounded;
    logic [fracWidth-1:0]  fracOut;
    logic                  overflowFlag;
    fpWord                 packedResult;

    // Highest set bit wins.
    always_comb
    begin
        leadZeros = lzWidth'(alignWidth);
        for (int i = 0; i < alignWidth; i++)
            if (bus.rawSum[i])
                leadZeros = lzWidth'(alignWidth - 1 - i);
    end

    // --------------------------------------------------------------------------
    // Normalize
    // --------------------------------------------------------------------------
    always_comb
    begin
        shiftLimit = {1'b0, bus.exponentOut} - 1'b1;
        if (bus.rawSum[sumWidth-1])
        begin
            normMantissa = bus.rawSum[sumWidth-1:1]
                         | {{(alignWidth - 1){1'b0}}, bus.rawSum[0]};
            expWork      = {1'b0, bus.exponentOut} + 1'b1;
        end
        else if (extWidth'(leadZeros) <= shiftLimit)
        begin
            normMantissa = bus.rawSum[alignWidth-1:0] << leadZeros;
            expWork      = {1'b0, bus.exponentOut} - extWidth'(leadZeros);
        end
        else
        begin
            // Stops at the subnormal boundary.
            normMantissa = bus.rawSum[alignWidth-1:0] << shiftLimit;
            expWork      = extWidth'(1);
        end
    end

    // --------------------------------------------------------------------------
    // Round
    // --------------------------------------------------------------------------
    assign roundBit  = normMantissa[guardPos];
    assign stickyAll = (|normMantissa[guardPos-1:0]) | bus.sticky;
    assign roundUp   = roundBit & (stickyAll | normMantissa[guardPos+1]);
    assign rounded   = {1'b0, normMantissa[alignWidth-1:guardPos+1]}
                     + {{(fracWidth + 1){1'b0}}, roundUp};

    // Rounding carry renormalizes.
    assign expFinal = expWork + {{expWidth{1'b0}}, rounded[fracWidth+1]};
    assign fracOut  = rounded[fracWidth+1] ? rounded[fracWidth:1] : rounded[fracWidth-1:0];

    assign overflowFlag = (expFinal >= extWidth'(expMax));
    assign bus.overflow = overflowFlag;
    assign bus.inexact  = roundBit | stickyAll | bus.shiftOverflow | overflowFlag;

    always_comb
    begin
        packedResult.fields.sign = bus.resultSign;
        if (overflowFlag)
        begin
            packedResult.fields.exponent = expWidth'(expMax);
            packedResult.fields.fraction = '0;
        end
        else
        begin
            // No hidden bit means subnormal or zero.
            if (rounded[fracWidth+1] | rounded[fracWidth])
                packedResult.fields.exponent = expFinal[expWidth-1:0];
            else
                packedResult.fields.exponent = '0;
            packedResult.fields.fraction = fracOut;
        end
    end

    assign bus.normResult = packedResult.bits;

endmodule

//--- verilog/MantissaAdder.sv
// Magnitudes are unsigned. Exact cancellation always gives +0.
`timescale 1ns/1ps

module MantissaAdder (fpbus.adder bus);
    import fpOpPkg::*;

    logic [sumWidth-1:0] extA;
    logic [sumWidth-1:0] extB;
    logic [sumWidth-1:0] sum;
    logic                aLarger;
    logic                sign;

    assign extA = {1'b0, bus.alignedMantissaA};
    assign extB = {1'b0, bus.alignedMantissaB};

    // Larger exponent wins outright.
    assign aLarger = bus.Aex | (~bus.Bex & (bus.alignedMantissaA >= bus.alignedMantissaB));

    always_comb
    begin
        if (bus.signA == bus.signB)
        begin
            sum  = extA + extB;
            sign = bus.signA;
        end
        else if (aLarger)
        begin
            sum  = extA - extB;
            sign = bus.signA;
        end
        else
        begin
            sum  = extB - extA;
            sign = bus.signB;
        end
    end

    assign bus.rawSum     = sum;
    assign bus.resultSign = (sum == '0) ? 1'b0 : sign;

endmodule

//--- verilog/Alignment.sv
// A zero or subnormal exponent counts as 1. Outputs are meaningless while bypassALU is set.
`timescale 1ns/1ps

module Alignment (fpbus.align bus);
    import fpFormatPkg::*;
    import fpOpPkg::*;

    logic                    denormA;
    logic                    denormB;
    logic [expWidth-1:0]     effExpA;
    logic [expWidth-1:0]     effExpB;
    logic [expWidth-1:0]     exponentDifferential;
    logic [alignWidth-1:0]   preA;
    logic [alignWidth-1:0]   preB;
    logic [alignWidth-1:0]   smallMantissa;
    logic [alignWidth-1:0]   shiftedMantissa;
    logic [2*alignWidth-1:0] wideShift;
    logic                    lostBits;

    // --------------------------------------------------------------------------
    // Control
    // --------------------------------------------------------------------------
    assign bus.Aex       = (bus.exponentA > bus.exponentB);
    assign bus.Bex       = (bus.exponentA < bus.exponentB);
    assign bus.bypassALU = bus.ANaN | bus.BNaN | bus.Ainf | bus.Binf | bus.Azero | bus.Bzero;

    assign denormA = bus.Asub | bus.Azero;
    assign denormB = bus.Bsub | bus.Bzero;
    assign effExpA = denormA ? expWidth'(1) : bus.exponentA;
    assign effExpB = denormB ? expWidth'(1) : bus.exponentB;

    // Hidden bit only for normal numbers.
    assign preA = {~denormA, bus.mantissaA, {(guardPos + 1){1'b0}}};
    assign preB = {~denormB, bus.mantissaB, {(guardPos + 1){1'b0}}};

    // --------------------------------------------------------------------------
    // Exponent select and differential
    // --------------------------------------------------------------------------
    always_comb
    begin
        if (bus.Bex)
        begin
            bus.exponentOut      = effExpB;
            exponentDifferential = effExpB - effExpA;
            smallMantissa        = preA;
        end
        else
        begin
            // Equal exponents land here with a zero shift.
            bus.exponentOut      = effExpA;
            exponentDifferential = effExpA - effExpB;
            smallMantissa        = preB;
        end
    end

    // --------------------------------------------------------------------------
    // Shift and sticky
    // --------------------------------------------------------------------------
    assign wideShift         = {smallMantissa, {alignWidth{1'b0}}} >> exponentDifferential;
    assign bus.shiftOverflow = (exponentDifferential >= alignWidth);

    always_comb
    begin
        if (bus.shiftOverflow)  lostBits = |smallMantissa;
        else                    lostBits = |wideShift[alignWidth-1:0];
    end

    assign bus.sticky = lostBits;

    // Sticky jammed into the LSB keeps subtraction rounding exact.
    assign shiftedMantissa = wideShift[2*alignWidth-1:alignWidth]
                           | {{(alignWidth - 1){1'b0}}, lostBits};

    always_comb
    begin
        if (bus.Bex)
        begin
            bus.alignedMantissaA = shiftedMantissa;
            bus.alignedMantissaB = preB;
        end
        else
        begin
            bus.alignedMantissaA = preA;
            bus.alignedMantissaB = shiftedMantissa;
        end
    end

endmodule

//--- verilog/OperandClassifier.sv
// Subtract is folded into the sign of B here, so later stages only ever add.
`timescale 1ns/1ps

module OperandClassifier (
    fpbus.classify       bus,
    input fpFormatPkg::fpWord opA,
    input fpFormatPkg::fpWord opB,
    input logic          subtract
);
    import fpFormatPkg::*;

    fpWord effectiveB;

    always_comb
    begin
        effectiveB             = opB;
        effectiveB.fields.sign = opB.fields.sign ^ subtract;
    end

    assign bus.signA     = opA.fields.sign;
    assign bus.signB     = effectiveB.fields.sign;
    assign bus.exponentA = opA.fields.exponent;
    assign bus.exponentB = opB.fields.exponent;
    assign bus.mantissaA = opA.fields.fraction;
    assign bus.mantissaB = opB.fields.fraction;

    // --------------------------------------------------------------------------
    // Class bits
    // --------------------------------------------------------------------------
    assign bus.ANaN  = (bus.exponentA == expWidth'(expMax)) && (bus.mantissaA != '0);
    assign bus.BNaN  = (bus.exponentB == expWidth'(expMax)) && (bus.mantissaB != '0);
    assign bus.Ainf  = (bus.exponentA == expWidth'(expMax)) && (bus.mantissaA == '0);
    assign bus.Binf  = (bus.exponentB == expWidth'(expMax)) && (bus.mantissaB == '0);
    assign bus.Azero = (bus.exponentA == '0) && (bus.mantissaA == '0);
    assign bus.Bzero = (bus.exponentB == '0) && (bus.mantissaB == '0);
    assign bus.Asub  = (bus.exponentA == '0) && (bus.mantissaA != '0);
    assign bus.Bsub  = (bus.exponentB == '0) && (bus.mantissaB != '0);

    // Result used whenever the arithmetic path is skipped.
    always_comb
    begin
        bus.bypassInvalid = 1'b0;
        if (bus.ANaN || bus.BNaN || (bus.Ainf && bus.Binf && (bus.signA != bus.signB)))
        begin
            bus.bypassResult  = quietNaN;
            bus.bypassInvalid = 1'b1;
        end
        else if (bus.Ainf)                  bus.bypassResult = opA.bits;
        else if (bus.Binf)                  bus.bypassResult = effectiveB.bits;
        else if (bus.Azero && bus.Bzero)    bus.bypassResult = {bus.signA & bus.signB, 31'b0};
        else if (bus.Azero)                 bus.bypassResult = effectiveB.bits;
        else                                bus.bypassResult = opA.bits;
    end

endmodule

//--- verilog/fpbus.sv
// All stage traffic is combinational and must settle within one clock cycle.
`timescale 1ns/1ps

interface fpbus;
    import fpFormatPkg::*;
    import fpOpPkg::*;

    logic [expWidth-1:0]   exponentA;
    logic [expWidth-1:0]   exponentB;
    logic [fracWidth-1:0]  mantissaA;
    logic [fracWidth-1:0]  mantissaB;
    logic                  signA;
    logic                  signB;           // Already flipped for subtract.
    logic                  ANaN, BNaN, Ainf, Binf, Azero, Bzero, Asub, Bsub;
    logic [31:0]           bypassResult;
    logic                  bypassInvalid;

    logic                  Aex, Bex;
    logic [expWidth-1:0]   exponentOut;     // Effective, never zero.
    logic [alignWidth-1:0] alignedMantissaA;
    logic [alignWidth-1:0] alignedMantissaB;
    logic                  sticky, shiftOverflow, bypassALU;

    logic [sumWidth-1:0]   rawSum;
    logic                  resultSign;

    logic [31:0]           normResult;
    logic                  overflow, inexact;

    modport classify (output exponentA, exponentB, mantissaA, mantissaB, signA, signB,
                      ANaN, BNaN, Ainf, Binf, Azero, Bzero, Asub, Bsub,
                      bypassResult, bypassInvalid);

    modport align (input exponentA, exponentB, mantissaA, mantissaB,
                   ANaN, BNaN, Ainf, Binf, Azero, Bzero, Asub, Bsub,
                   output Aex, Bex, exponentOut, alignedMantissaA, alignedMantissaB,
                   sticky, shiftOverflow, bypassALU);

    modport adder (input alignedMantissaA, alignedMantissaB, signA, signB, Aex, Bex,
                   output rawSum, resultSign);

    modport normalize (input rawSum, resultSign, exponentOut, sticky, shiftOverflow,
                       output normResult, overflow, inexact);

    modport top (input bypassALU, bypassResult, bypassInvalid, normResult, overflow, inexact);

endinterface

//--- verilog/fpOpPkg.sv
// Datapath sizing for one add/subtract with 8 guard bits and round to nearest-even only.
package fpOpPkg;

    // Hidden bit, 23 fraction bits, 8 guard bits.
    localparam int alignWidth = 32;

    localparam int sumWidth = alignWidth + 1;           // Room for the carry.

    // First bit below the fraction once aligned.
    localparam int guardPos = 7;

    // Edges from the sampling edge of req up to ack.
    localparam int ackLatency = 2;

endpackage

//--- verilog/fpFormatPkg.sv
// Single precision only. NaN results are always the canonical quiet NaN.
package fpFormatPkg;

    // --------------------------------------------------------------------------
    // Field widths and encodings
    // --------------------------------------------------------------------------
    localparam int expWidth  = 8;
    localparam int fracWidth = 23;
    localparam int expBias   = 127;
    localparam int expMax    = 2 * expBias + 1;          // All ones marks inf and NaN.

    localparam logic [31:0] quietNaN = 32'h7FC0_0000;

    // --------------------------------------------------------------------------
    // Operand word, seen either raw or split into its fields
    // --------------------------------------------------------------------------
    typedef union packed
    {
        logic [31:0] bits;
        struct packed
        {
            logic                 sign;
            logic [expWidth-1:0]  exponent;
            logic [fracWidth-1:0] fraction;
        } fields;
    } fpWord;

endpackage
